// ==== src/tx_pkg.sv ====
`default_nettype none

package tx_pkg;

	// frame generator states, in transmit order
	typedef enum logic [1:0] {
		BIT_SYNC   = 2'd0,	// preamble ones and closing zero
		PK_HEADER  = 2'd1,	// packet header zeros
		HMM_INFO   = 2'd2,	// four information bits d3..d6
		HMM_PARITY = 2'd3	// three parity bits d0..d2
	} frame_state_t;

	localparam int SYNC_ONES     = 10;	// preamble ones before the zero
	localparam int HEADER_LEN    = 7;	// header zeros
	localparam int DEF_CODEWORDS = 128;	// codewords per frame by default

	localparam int SAMPLE_W        = 8;	// signed carrier sample
	localparam int SAMPLES_PER_BIT = 8;	// one carrier period per bit
	localparam int PHASE_W         = $clog2(SAMPLES_PER_BIT);

	// one sine period, peak 127
	localparam logic signed [SAMPLE_W-1:0] CARRIER_TABLE [SAMPLES_PER_BIT] = '{
		8'sd0,
		8'sd90,
		8'sd127,
		8'sd90,
		8'sd0,
		-8'sd90,
		-8'sd127,
		-8'sd90
	};

endpackage

`default_nettype wire

// ==== src/nibble_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_unpacker (
	input  wire logic       clk_c,
	input  wire logic       rst_n,
	input  wire logic       byte_req,	// four-phase request from host
	input  wire logic [7:0] byte_data,
	output logic            byte_ack,
	output logic            info,		// current bit, lsb first
	output logic            info_valid,	// a full nibble is waiting
	input  wire logic       ready_info	// consume one bit
);

	typedef enum logic {
		ACK_IDLE = 1'b0,	// waiting for req
		ACK_HIGH = 1'b1		// ack raised, waiting for req to drop
	} ack_state_t;

	ack_state_t ack_state;
	logic [7:0] shift_buf;	// unread bits sit at the bottom
	logic [3:0] bit_cnt;	// 0..8 unread bits
	logic       capture;
	logic       shift;

	// a new byte only when ack is low and every bit has been read
	assign capture = (ack_state == ACK_IDLE) && byte_req && (bit_cnt == 4'd0);
	assign shift   = ready_info && (bit_cnt != 4'd0);

	always_ff @(posedge clk_c or negedge rst_n) begin
		if (!rst_n) begin
			ack_state <= ACK_IDLE;
		end else begin
			case (ack_state)
				ACK_IDLE: begin
					if (capture)
						ack_state <= ACK_HIGH;
				end
				ACK_HIGH: begin
					if (!byte_req)
						ack_state <= ACK_IDLE;	// ack falls, handshake done
				end
				default: ack_state <= ACK_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_c or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= 4'd0;
		end else if (capture) begin
			bit_cnt <= 4'd8;
		end else if (shift) begin
			bit_cnt <= bit_cnt - 4'd1;
		end
	end

	always_ff @(posedge clk_c) begin
		if (capture)
			shift_buf <= byte_data;
		else if (shift)
			shift_buf <= {1'b0, shift_buf[7:1]};	// next bit down to lsb
	end

	assign byte_ack   = (ack_state == ACK_HIGH);
	assign info       = shift_buf[0];
	assign info_valid = (bit_cnt >= 4'd4);

endmodule

`default_nettype wire

// ==== src/frame_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_gen #(
	parameter int CODEWORDS_PER_FRAME = tx_pkg::DEF_CODEWORDS
) (
	input  wire logic clk_c,
	input  wire logic rst_n,
	input  wire logic info,
	input  wire logic info_valid,
	output logic      ready_info,
	output logic      seq_s,
	output logic      flag_seq_s,	// seq_s holds a bit
	input  wire logic seq_ready
);

	import tx_pkg::*;

	localparam int CW_W = (CODEWORDS_PER_FRAME > 1) ? $clog2(CODEWORDS_PER_FRAME) : 1;

	localparam logic [3:0]      SYNC_LAST   = 4'(SYNC_ONES);	// the closing zero
	localparam logic [3:0]      HEADER_LAST = 4'(HEADER_LEN - 1);
	localparam logic [3:0]      INFO_LAST   = 4'd3;
	localparam logic [3:0]      PARITY_LAST = 4'd2;
	localparam logic [CW_W-1:0] CW_LAST     = CW_W'(CODEWORDS_PER_FRAME - 1);

	frame_state_t    state;
	logic [3:0]      bit_cnt;	// position inside the current state
	logic [CW_W-1:0] cw_cnt;	// codeword within the frame
	logic            d3, d4, d5, d6;
	logic            d0, d1, d2;
	logic            load_en;	// output register free this cycle
	logic            bit_avail;
	logic            next_bit;
	logic            take;		// next bit moves into the output register

	// parity from the captured information bits
	assign d2 = d6 ^ d5 ^ d4;
	assign d1 = d6 ^ d5 ^ d3;
	assign d0 = d6 ^ d4 ^ d3;

	assign load_en = !flag_seq_s || seq_ready;

	always_comb begin
		next_bit  = 1'b0;
		bit_avail = 1'b1;
		case (state)
			BIT_SYNC:  next_bit = (bit_cnt != SYNC_LAST);
			PK_HEADER: next_bit = 1'b0;
			HMM_INFO: begin
				next_bit  = info;
				bit_avail = (bit_cnt != 4'd0) || info_valid;	// wait for a whole nibble
			end
			HMM_PARITY: begin
				case (bit_cnt)
					4'd0:    next_bit = d0;
					4'd1:    next_bit = d1;
					default: next_bit = d2;
				endcase
			end
			default: bit_avail = 1'b0;
		endcase
	end

	assign take       = load_en && bit_avail;
	assign ready_info = (state == HMM_INFO) && take;

	always_ff @(posedge clk_c or negedge rst_n) begin
		if (!rst_n) begin
			state   <= BIT_SYNC;
			bit_cnt <= 4'd0;
			cw_cnt  <= '0;
		end else if (take) begin
			bit_cnt <= bit_cnt + 4'd1;
			case (state)
				BIT_SYNC: begin
					if (bit_cnt == SYNC_LAST) begin
						state   <= PK_HEADER;
						bit_cnt <= 4'd0;
					end
				end
				PK_HEADER: begin
					if (bit_cnt == HEADER_LAST) begin
						state   <= HMM_INFO;
						bit_cnt <= 4'd0;
					end
				end
				HMM_INFO: begin
					if (bit_cnt == INFO_LAST) begin
						state   <= HMM_PARITY;
						bit_cnt <= 4'd0;
					end
				end
				HMM_PARITY: begin
					if (bit_cnt == PARITY_LAST) begin
						bit_cnt <= 4'd0;
						if (cw_cnt == CW_LAST) begin
							state  <= PK_HEADER;	// next frame, no new preamble
							cw_cnt <= '0;
						end else begin
							state  <= HMM_INFO;
							cw_cnt <= cw_cnt + 1'b1;
						end
					end
				end
				default: state <= BIT_SYNC;
			endcase
		end
	end

	// capture d3..d6 as they go out
	always_ff @(posedge clk_c) begin
		if (ready_info) begin
			case (bit_cnt)
				4'd0:    d3 <= info;
				4'd1:    d4 <= info;
				4'd2:    d5 <= info;
				default: d6 <= info;
			endcase
		end
	end

	always_ff @(posedge clk_c or negedge rst_n) begin
		if (!rst_n)
			flag_seq_s <= 1'b0;
		else if (load_en)
			flag_seq_s <= bit_avail;	// drops while waiting for a nibble
	end

	always_ff @(posedge clk_c) begin
		if (take)
			seq_s <= next_bit;
	end

endmodule

`default_nettype wire

// ==== src/diff_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module diff_encoder (
	input  wire logic clk_c,
	input  wire logic rst_n,
	input  wire logic seq_s,
	input  wire logic flag_seq_s,
	output logic      seq_ready,
	output logic      enc_bit,		// also the previous encoded bit
	output logic      enc_valid,
	input  wire logic enc_ready
);

	logic take_in;

	// free when empty or being drained this cycle
	assign seq_ready = !enc_valid || enc_ready;
	assign take_in   = flag_seq_s && seq_ready;

	always_ff @(posedge clk_c or negedge rst_n) begin
		if (!rst_n) begin
			enc_bit   <= 1'b0;	// reference level for the first bit
			enc_valid <= 1'b0;
		end else if (take_in) begin
			enc_bit   <= seq_s ^ enc_bit;
			enc_valid <= 1'b1;
		end else if (enc_ready) begin
			enc_valid <= 1'b0;	// bit taken, nothing new
		end
	end

endmodule

`default_nettype wire

// ==== src/bpsk_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpsk_mapper (
	input  wire logic                        clk_c,
	input  wire logic                        rst_n,
	input  wire logic                        enc_bit,
	input  wire logic                        enc_valid,
	output logic                             enc_ready,
	output logic signed [tx_pkg::SAMPLE_W-1:0] sample,
	output logic                             sample_valid
);

	import tx_pkg::*;

	localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(SAMPLES_PER_BIT - 1);

	logic               busy;	// a bit is being played out
	logic               bit_r;
	logic [PHASE_W-1:0] phase;	// index into the carrier table
	logic               take;
	logic               last_phase;

	assign last_phase = (phase == PHASE_LAST);

	// next bit goes in on the last sample, so no gap between bits
	assign enc_ready = !busy || last_phase;
	assign take      = enc_valid && enc_ready;

	always_ff @(posedge clk_c or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			phase <= '0;
		end else if (take) begin
			busy  <= 1'b1;
			phase <= '0;
		end else if (busy) begin
			if (last_phase)
				busy <= 1'b0;	// nothing queued, pause output
			else
				phase <= phase + 1'b1;
		end
	end

	always_ff @(posedge clk_c) begin
		if (take)
			bit_r <= enc_bit;
	end

	// a zero bit sends the carrier inverted
	always_comb begin
		if (bit_r)
			sample = CARRIER_TABLE[phase];
		else
			sample = -CARRIER_TABLE[phase];
	end

	assign sample_valid = busy;

endmodule

`default_nettype wire

// ==== src/tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_top #(
	parameter int CODEWORDS_PER_FRAME = tx_pkg::DEF_CODEWORDS
) (
	input  wire logic                          clk_c,
	input  wire logic                          rst_n,
	input  wire logic                          byte_req,
	input  wire logic [7:0]                    byte_data,
	output logic                               byte_ack,
	output logic signed [tx_pkg::SAMPLE_W-1:0] sample,
	output logic                               sample_valid
);

	logic info;
	logic info_valid;
	logic ready_info;
	logic seq_s;
	logic flag_seq_s;
	logic seq_ready;
	logic enc_bit;
	logic enc_valid;
	logic enc_ready;

	nibble_unpacker u_unpacker (
		.clk_c      (clk_c),
		.rst_n      (rst_n),
		.byte_req   (byte_req),
		.byte_data  (byte_data),
		.byte_ack   (byte_ack),
		.info       (info),
		.info_valid (info_valid),
		.ready_info (ready_info)
	);

	frame_gen #(
		.CODEWORDS_PER_FRAME (CODEWORDS_PER_FRAME)
	) u_frame_gen (
		.clk_c      (clk_c),
		.rst_n      (rst_n),
		.info       (info),
		.info_valid (info_valid),
		.ready_info (ready_info),
		.seq_s      (seq_s),
		.flag_seq_s (flag_seq_s),
		.seq_ready  (seq_ready)
	);

	diff_encoder u_diff_enc (
		.clk_c      (clk_c),
		.rst_n      (rst_n),
		.seq_s      (seq_s),
		.flag_seq_s (flag_seq_s),
		.seq_ready  (seq_ready),
		.enc_bit    (enc_bit),
		.enc_valid  (enc_valid),
		.enc_ready  (enc_ready)
	);

	bpsk_mapper u_mapper (
		.clk_c        (clk_c),
		.rst_n        (rst_n),
		.enc_bit      (enc_bit),
		.enc_valid    (enc_valid),
		.enc_ready    (enc_ready),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

endmodule

`default_nettype wire

// ==== test/tb_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tx_top;

	import tx_pkg::*;

	localparam int CW_PER_FRAME = 4;
	localparam int NUM_ROWS     = 8;
	localparam int CLK_HALF     = 2;	// 4 ns period
	localparam int FALL_LIMIT   = 4;
	localparam logic [31:0] SEED = 32'h2ab9_49c9;
	// the previous byte may still be draining at one bit per eight cycles
	localparam int ACK_LIMIT = 16 + (SYNC_ONES + 1 + HEADER_LEN + 7 + 4) * SAMPLES_PER_BIT;
	localparam int SINE [SAMPLES_PER_BIT] = '{0, 90, 127, 90, 0, -90, -127, -90};

	typedef struct packed {
		logic [7:0]  data;
		logic [15:0] gap;	// idle cycles before the byte
		logic [6:0]  cw_lo;	// low nibble codeword, bit 6 goes out first
		logic [6:0]  cw_hi;	// high nibble codeword
	} stim_row_t;

	// codewords in transmit order d3 d4 d5 d6 d0 d1 d2
	localparam stim_row_t STIM [NUM_ROWS] = '{
		'{8'h00, 16'd2,   7'b0000000, 7'b0000000},
		'{8'hFF, 16'd0,   7'b1111111, 7'b1111111},
		'{8'hA5, 16'd5,   7'b1010101, 7'b0101010},
		'{8'h3C, 16'd1,   7'b0011100, 7'b1100011},
		'{8'h5A, 16'd300, 7'b0101010, 7'b1010101},
		'{8'h0F, 16'd0,   7'b1111111, 7'b0000000},
		'{8'hC3, 16'd450, 7'b1100011, 7'b0011100},
		'{8'h96, 16'd3,   7'b0110110, 7'b1001001}
	};

	logic                       clk_c;
	logic                       rst_n;
	logic                       byte_req;
	logic [7:0]                 byte_data;
	logic                       byte_ack;
	logic signed [SAMPLE_W-1:0] sample;
	logic                       sample_valid;

	logic       exp_bits [$];	// model bit stream before encoding
	logic [7:0] exp_q [$];		// expected samples, oldest first
	int         gap_cycles [NUM_ROWS];
	int         error_count;
	int         checked;
	int         exp_total;
	logic       prev_req;
	logic       prev_ack;
	logic       seen_sample;
	logic       pause_seen;

	tx_top #(
		.CODEWORDS_PER_FRAME (CW_PER_FRAME)
	) UUT (
		.clk_c        (clk_c),
		.rst_n        (rst_n),
		.byte_req     (byte_req),
		.byte_data    (byte_data),
		.byte_ack     (byte_ack),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	always #CLK_HALF clk_c = ~clk_c;

	task check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("FAIL %s got %02h expected %02h at %0t", name, got, exp, $time);
		end
	endtask

	task append_part(input frame_state_t part, input logic [6:0] cw);
		int i;
		case (part)
			BIT_SYNC: begin
				for (i = 0; i < SYNC_ONES; i++)
					exp_bits.push_back(1'b1);
				exp_bits.push_back(1'b0);	// closing zero
			end
			PK_HEADER: begin
				for (i = 0; i < HEADER_LEN; i++)
					exp_bits.push_back(1'b0);
			end
			HMM_INFO: begin
				for (i = 6; i >= 3; i--)
					exp_bits.push_back(cw[i]);
			end
			default: begin
				for (i = 2; i >= 0; i--)
					exp_bits.push_back(cw[i]);
			end
		endcase
	endtask

	task build_model;
		int         r;
		int         h;
		int         n;
		int         b;
		int         p;
		logic       enc;
		logic [6:0] cw;
		exp_bits.delete();
		exp_q.delete();
		append_part(BIT_SYNC, 7'd0);
		append_part(PK_HEADER, 7'd0);
		n = 0;
		for (r = 0; r < NUM_ROWS; r++) begin
			for (h = 0; h < 2; h++) begin
				cw = (h == 0) ? STIM[r].cw_lo : STIM[r].cw_hi;
				append_part(HMM_INFO, cw);
				append_part(HMM_PARITY, cw);
				n++;
				if (n % CW_PER_FRAME == 0)
					append_part(PK_HEADER, 7'd0);	// next frame header, no preamble
			end
		end
		enc = 1'b0;
		for (b = 0; b < exp_bits.size(); b++) begin
			enc = exp_bits[b] ^ enc;
			for (p = 0; p < SAMPLES_PER_BIT; p++)
				exp_q.push_back(enc ? 8'(SINE[p]) : 8'(-SINE[p]));
		end
		exp_total = exp_q.size();
	endtask

	task send_byte(input logic [7:0] data, input int gap);
		int waited;
		@(posedge clk_c);
		repeat (gap) @(posedge clk_c);
		#1;
		byte_data = data;
		byte_req  = 1'b1;
		waited    = 0;
		do begin
			@(negedge clk_c);
			waited++;
		end while (!byte_ack && waited < ACK_LIMIT);
		if (!byte_ack) begin
			error_count++;
			$display("byte_ack did not rise within %0d cycles for byte %02h", ACK_LIMIT, data);
		end
		@(posedge clk_c);
		#1;
		byte_req = 1'b0;
		waited   = 0;
		do begin
			@(negedge clk_c);
			waited++;
		end while (byte_ack && waited < FALL_LIMIT);
		if (byte_ack) begin
			error_count++;
			$display("byte_ack stayed high after byte_req dropped for byte %02h", data);
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk_c) begin
		if (!rst_n) begin
			prev_req = 1'b0;
			prev_ack = 1'b0;
		end else begin
			if (byte_ack && !prev_ack)
				check_value("byte_req at byte_ack rise", {7'd0, prev_req}, 8'h01);
			if (!byte_ack && prev_ack)
				check_value("byte_req at byte_ack fall", {7'd0, prev_req}, 8'h00);
			prev_req = byte_req;
			prev_ack = byte_ack;
			if (sample_valid) begin
				if (exp_q.size() == 0) begin
					error_count++;
					$display("sample_valid high with no sample left in the model, value %02h",
						sample);
				end else begin
					check_value("sample", sample, exp_q.pop_front());
					checked++;
				end
				seen_sample = 1'b1;
			end else if (seen_sample && exp_q.size() != 0) begin
				pause_seen = 1'b1;	// gap in the middle of the stream
			end
		end
	end

	initial begin
		int r;
		clk_c       = 1'b0;
		rst_n       = 1'b0;
		byte_req    = 1'b0;
		byte_data   = 8'h00;
		error_count = 0;
		checked     = 0;
		seen_sample = 1'b0;
		pause_seen  = 1'b0;
		prev_req    = 1'b0;
		prev_ack    = 1'b0;
		void'($urandom(SEED));
		for (r = 0; r < NUM_ROWS; r++)
			gap_cycles[r] = int'(STIM[r].gap) + int'($urandom % 32'd4);
		build_model();
		repeat (3) @(posedge clk_c);
		#1;
		rst_n = 1'b1;
		@(negedge clk_c);
		check_value("sample_valid after reset", {7'd0, sample_valid}, 8'h00);
		check_value("byte_ack after reset", {7'd0, byte_ack}, 8'h00);
		for (r = 0; r < NUM_ROWS; r++)
			send_byte(STIM[r].data, gap_cycles[r]);
		while (exp_q.size() != 0)
			@(negedge clk_c);
		repeat (64) @(negedge clk_c);	// trailing samples would show up here
		if (!pause_seen) begin
			error_count++;
			$display("sample_valid never paused during the long idle gaps");
		end
		$display("error count %0d, samples checked %0d of %0d",
			error_count, checked, exp_total);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : run_limit
		int limit;
		int r;
		limit = (NUM_ROWS * 2 * 7 + SYNC_ONES + 1
			+ (NUM_ROWS * 2 / CW_PER_FRAME + 1) * HEADER_LEN) * SAMPLES_PER_BIT * 4;
		for (r = 0; r < NUM_ROWS; r++)
			limit += int'(STIM[r].gap) + 3;	// table gap plus random extra
		repeat (limit) @(posedge clk_c);
		$display("timeout after %0d cycles, %0d samples never arrived", limit, exp_q.size());
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/tx_pkg.sv
src/nibble_unpacker.sv
src/frame_gen.sv
src/diff_encoder.sv
src/bpsk_mapper.sv
src/tx_top.sv
test/tb_tx_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_tx_top \
	-f filelist.f \
	-o sim_tx_top

./obj_dir/sim_tx_top | tee sim.log

if grep -qx "Finished with errors" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

if ! grep -qx "Finished with no errors" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
